// File: hdl/isaPkg.sv
`default_nettype none

package isaPkg;

	typedef logic [31:0] Word;
	typedef logic [4:0] RegAddr;
	typedef logic [5:0] Opcode;
	typedef logic [5:0] Funct;
	typedef logic [15:0] Imm;

	// ==================================================
	// instruction field positions (lsb of each field)
	// ==================================================
	localparam int OpcodeLsb = 26;
	localparam int RsLsb = 21;
	localparam int RtLsb = 16;
	localparam int RdLsb = 11;
	localparam int FunctLsb = 0;
	localparam int ImmLsb = 0;

	localparam Opcode OpArith = 6'b000000; // all R-type ops share this
	localparam Opcode OpAddi = 6'b001000;
	localparam Opcode OpAddiu = 6'b001001;

	localparam Funct FnAdd = 6'b100000;
	localparam Funct FnSub = 6'b100010;
	localparam Funct FnAnd = 6'b100100;
	localparam Funct FnBreak = 6'b001101;
	localparam Funct FnRte = 6'b010011;

endpackage

`default_nettype wire

// File: hdl/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

	typedef enum logic [2:0] {
		FetchReq,
		FetchWait,
		Decode,
		Execute,
		WriteBack,
		Trap,
		Return
	} ControlState;

	// ==================================================
	// datapath selects
	// ==================================================
	typedef enum logic [1:0] {
		AluAdd = 2'b01,
		AluSub = 2'b10,
		AluAnd = 2'b11
	} AluOp;

	typedef enum logic {
		SrcAPc = 1'b0,
		SrcARegA = 1'b1
	} AluSrcA;

	typedef enum logic [1:0] {
		SrcBRegB = 2'b00,
		SrcBFour = 2'b01,
		SrcBImm = 2'b10
	} AluSrcB;

	typedef enum logic [1:0] {
		PcAlu = 2'b00,
		PcEpc = 2'b10,
		PcTrap = 2'b11
	} PcSource;

	typedef enum logic {
		DstRt = 1'b0,
		DstRd = 1'b1
	} RegDst;

endpackage

`default_nettype wire

// File: hdl/ctrlIf.sv
`timescale 1ns/100ps
`default_nettype none

interface ctrlIf;

	logic pcWrite;
	logic epcWrite;
	logic irWrite;
	logic operandLoad;
	logic aluOutLoad;
	logic regWrite;
	ctrlPkg::AluOp aluOp;
	ctrlPkg::AluSrcA aluSrcA;
	ctrlPkg::AluSrcB aluSrcB;
	ctrlPkg::PcSource pcSource;
	ctrlPkg::RegDst regDst;
	isaPkg::Opcode opcode; // decoded fields come back from the instruction register
	isaPkg::Funct funct;

	modport control (
		output pcWrite, epcWrite, irWrite, operandLoad, aluOutLoad, regWrite,
		output aluOp, aluSrcA, aluSrcB, pcSource, regDst,
		input opcode, funct
	);

	modport datapath (
		input pcWrite, epcWrite, irWrite, operandLoad, aluOutLoad, regWrite,
		input aluOp, aluSrcA, aluSrcB, pcSource, regDst,
		output opcode, funct
	);

endinterface

`default_nettype wire

// File: hdl/memWaitTimer.sv
`timescale 1ns/100ps
`default_nettype none

module memWaitTimer #(
	parameter int MemLatency = 3
) (
	input logic clk,
	input logic reset,
	input logic start,
	output logic done
);

	localparam int CountWidth = $clog2(MemLatency + 1);

	logic [CountWidth-1:0] count;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (start) begin
			count <= CountWidth'(MemLatency);
		end else if (count != '0) begin
			count <= count - CountWidth'(1);
		end
	end

	assign done = count == CountWidth'(1); // last cycle of the count, one pulse per start

	noRestartWhileBusy: assert property (@(posedge clk) disable iff (reset)
		start |-> count == '0)
		else $error("fetch started while the memory timer was still running");

endmodule

`default_nettype wire

// File: hdl/mainControl.sv
`timescale 1ns/100ps
`default_nettype none

module mainControl (
	input logic clk,
	input logic reset,
	ctrlIf.control ctrl,
	output logic timerStart,
	input logic timerDone,
	output logic instrRead
);

	ctrlPkg::ControlState state;
	ctrlPkg::ControlState nextState;
	logic isRType;
	logic isImmArith;

	assign isRType = ctrl.opcode == isaPkg::OpArith;
	assign isImmArith = (ctrl.opcode == isaPkg::OpAddi) || (ctrl.opcode == isaPkg::OpAddiu);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ctrlPkg::FetchReq;
		end else begin
			state <= nextState;
		end
	end

	// ==================================================
	// next state
	// ==================================================
	always_comb begin
		nextState = state;
		case (state)
			ctrlPkg::FetchReq: nextState = ctrlPkg::FetchWait;
			ctrlPkg::FetchWait: begin
				if (timerDone) begin
					nextState = ctrlPkg::Decode;
				end
			end
			ctrlPkg::Decode: begin
				nextState = ctrlPkg::FetchReq; // unknown codes fall through as no-ops
				if (isImmArith) begin
					nextState = ctrlPkg::Execute;
				end else if (isRType) begin
					case (ctrl.funct)
						isaPkg::FnAdd, isaPkg::FnSub, isaPkg::FnAnd: nextState = ctrlPkg::Execute;
						isaPkg::FnBreak: nextState = ctrlPkg::Trap;
						isaPkg::FnRte: nextState = ctrlPkg::Return;
						default: nextState = ctrlPkg::FetchReq;
					endcase
				end
			end
			ctrlPkg::Execute: nextState = ctrlPkg::WriteBack;
			default: nextState = ctrlPkg::FetchReq;
		endcase
	end

	// ==================================================
	// strobes and selects
	// ==================================================
	always_comb begin
		instrRead = 1'b0;
		timerStart = 1'b0;
		ctrl.pcWrite = 1'b0;
		ctrl.epcWrite = 1'b0;
		ctrl.irWrite = 1'b0;
		ctrl.operandLoad = 1'b0;
		ctrl.aluOutLoad = 1'b0;
		ctrl.regWrite = 1'b0;
		ctrl.aluOp = ctrlPkg::AluAdd; // pc + 4 unless told otherwise
		ctrl.aluSrcA = ctrlPkg::SrcAPc;
		ctrl.aluSrcB = ctrlPkg::SrcBFour;
		ctrl.pcSource = ctrlPkg::PcAlu;
		ctrl.regDst = ctrlPkg::DstRt;
		if (isRType) begin
			ctrl.regDst = ctrlPkg::DstRd;
		end
		case (state)
			ctrlPkg::FetchReq: begin
				instrRead = !reset; // the first request goes out once reset is released
				timerStart = !reset;
			end
			ctrlPkg::FetchWait: begin
				ctrl.irWrite = timerDone; // data is valid only in the last wait cycle
				ctrl.pcWrite = timerDone;
			end
			ctrlPkg::Decode: ctrl.operandLoad = 1'b1;
			ctrlPkg::Execute: begin
				ctrl.aluOutLoad = 1'b1;
				ctrl.aluSrcA = ctrlPkg::SrcARegA;
				ctrl.aluSrcB = ctrlPkg::SrcBImm;
				if (isRType) begin
					ctrl.aluSrcB = ctrlPkg::SrcBRegB;
					case (ctrl.funct)
						isaPkg::FnSub: ctrl.aluOp = ctrlPkg::AluSub;
						isaPkg::FnAnd: ctrl.aluOp = ctrlPkg::AluAnd;
						default: ctrl.aluOp = ctrlPkg::AluAdd;
					endcase
				end
			end
			ctrlPkg::WriteBack: ctrl.regWrite = 1'b1;
			ctrlPkg::Trap: begin
				ctrl.epcWrite = 1'b1; // pc already points past the break
				ctrl.pcWrite = 1'b1;
				ctrl.pcSource = ctrlPkg::PcTrap;
			end
			ctrlPkg::Return: begin
				ctrl.pcWrite = 1'b1;
				ctrl.pcSource = ctrlPkg::PcEpc;
			end
			default: ;
		endcase
	end

	doneOnlyInWait: assert property (@(posedge clk) disable iff (reset)
		timerDone |-> state == ctrlPkg::FetchWait)
		else $error("memory timer finished outside the fetch wait");

endmodule

`default_nettype wire

// File: hdl/pcUnit.sv
`timescale 1ns/100ps
`default_nettype none

module pcUnit #(
	parameter isaPkg::Word ResetPc = '0,
	parameter isaPkg::Word TrapVector = 32'h100
) (
	input logic clk,
	input logic reset,
	ctrlIf.datapath ctrl,
	input isaPkg::Word instrData,
	input isaPkg::Word aluResult,
	output isaPkg::Word pc,
	output isaPkg::RegAddr rsAddr,
	output isaPkg::RegAddr rtAddr,
	output isaPkg::RegAddr rdAddr,
	output isaPkg::Imm imm
);

	isaPkg::Word epc;
	isaPkg::Word ir;
	isaPkg::Word nextPc;

	always_comb begin
		case (ctrl.pcSource)
			ctrlPkg::PcEpc: nextPc = epc;
			ctrlPkg::PcTrap: nextPc = TrapVector;
			default: nextPc = aluResult;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= ResetPc;
			ir <= '0;
		end else begin
			if (ctrl.pcWrite) begin
				pc <= nextPc;
			end
			if (ctrl.irWrite) begin
				ir <= instrData;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.epcWrite) begin
			epc <= pc;
		end
	end

	assign ctrl.opcode = ir[isaPkg::OpcodeLsb +: $bits(isaPkg::Opcode)];
	assign ctrl.funct = ir[isaPkg::FunctLsb +: $bits(isaPkg::Funct)];
	assign rsAddr = ir[isaPkg::RsLsb +: $bits(isaPkg::RegAddr)];
	assign rtAddr = ir[isaPkg::RtLsb +: $bits(isaPkg::RegAddr)];
	assign rdAddr = ir[isaPkg::RdLsb +: $bits(isaPkg::RegAddr)];
	assign imm = ir[isaPkg::ImmLsb +: $bits(isaPkg::Imm)];

endmodule

`default_nettype wire

// File: hdl/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile (
	input logic clk,
	input logic reset,
	ctrlIf.datapath ctrl,
	input isaPkg::RegAddr rsAddr,
	input isaPkg::RegAddr rtAddr,
	input isaPkg::RegAddr rdAddr,
	input isaPkg::Word writeData,
	output isaPkg::Word readA,
	output isaPkg::Word readB,
	output isaPkg::RegAddr writeAddr
);

	localparam int RegCount = 2 ** $bits(isaPkg::RegAddr);

	isaPkg::Word regs [RegCount];

	assign writeAddr = (ctrl.regDst == ctrlPkg::DstRd) ? rdAddr : rtAddr;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < RegCount; i++) begin
				regs[i] <= '0;
			end
		end else if (ctrl.regWrite && writeAddr != '0) begin
			regs[writeAddr] <= writeData; // r0 is never written so it stays zero
		end
	end

	assign readA = regs[rsAddr];
	assign readB = regs[rtAddr];

	knownWriteAddr: assert property (@(posedge clk) disable iff (reset)
		ctrl.regWrite |-> !$isunknown(writeAddr))
		else $error("register write with an unknown destination");

endmodule

`default_nettype wire

// File: hdl/execUnit.sv
`timescale 1ns/100ps
`default_nettype none

module execUnit (
	input logic clk,
	input logic reset,
	ctrlIf.datapath ctrl,
	input isaPkg::Word pc,
	input isaPkg::Imm imm,
	input isaPkg::Word readA,
	input isaPkg::Word readB,
	output isaPkg::Word aluResult,
	output isaPkg::Word aluOut
);

	isaPkg::Word regA;
	isaPkg::Word regB;
	isaPkg::Word srcA;
	isaPkg::Word srcB;
	isaPkg::Word signExtImm;

	always_ff @(posedge clk) begin
		if (ctrl.operandLoad) begin
			regA <= readA;
			regB <= readB;
		end
	end

	// addi and addiu both extend the sign, overflow is ignored
	assign signExtImm = isaPkg::Word'(signed'(imm));

	assign srcA = (ctrl.aluSrcA == ctrlPkg::SrcARegA) ? regA : pc;

	always_comb begin
		case (ctrl.aluSrcB)
			ctrlPkg::SrcBRegB: srcB = regB;
			ctrlPkg::SrcBImm: srcB = signExtImm;
			default: srcB = 32'd4;
		endcase
	end

	always_comb begin
		case (ctrl.aluOp)
			ctrlPkg::AluSub: aluResult = srcA - srcB;
			ctrlPkg::AluAnd: aluResult = srcA & srcB;
			default: aluResult = srcA + srcB;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			aluOut <= '0;
		end else if (ctrl.aluOutLoad) begin
			aluOut <= aluResult;
		end
	end

endmodule

`default_nettype wire

// File: hdl/mipsCore.sv
`timescale 1ns/100ps
`default_nettype none

module mipsCore #(
	parameter int MemLatency = 3,
	parameter isaPkg::Word ResetPc = '0,
	parameter isaPkg::Word TrapVector = 32'h100
) (
	input logic clk,
	input logic reset,
	input isaPkg::Word instrData,
	output logic instrRead,
	output isaPkg::Word instrAddr,
	output logic regWriteEn,
	output isaPkg::RegAddr regWriteAddr,
	output isaPkg::Word regWriteData
);

	ctrlIf ctrl ();

	logic timerStart;
	logic timerDone;
	isaPkg::Word pc;
	isaPkg::Word aluResult;
	isaPkg::Word aluOut;
	isaPkg::Word readA;
	isaPkg::Word readB;
	isaPkg::RegAddr rsAddr;
	isaPkg::RegAddr rtAddr;
	isaPkg::RegAddr rdAddr;
	isaPkg::RegAddr writeAddr;
	isaPkg::Imm imm;

	// ==================================================
	// control
	// ==================================================
	mainControl control (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl.control),
		.timerStart(timerStart),
		.timerDone(timerDone),
		.instrRead(instrRead)
	);

	memWaitTimer #(.MemLatency(MemLatency)) timer (
		.clk(clk),
		.reset(reset),
		.start(timerStart),
		.done(timerDone)
	);

	// ==================================================
	// datapath
	// ==================================================
	pcUnit #(.ResetPc(ResetPc), .TrapVector(TrapVector)) pcBlock (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl.datapath),
		.instrData(instrData),
		.aluResult(aluResult),
		.pc(pc),
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.rdAddr(rdAddr),
		.imm(imm)
	);

	regFile regs (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl.datapath),
		.rsAddr(rsAddr),
		.rtAddr(rtAddr),
		.rdAddr(rdAddr),
		.writeData(aluOut),
		.readA(readA),
		.readB(readB),
		.writeAddr(writeAddr)
	);

	execUnit exec (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl.datapath),
		.pc(pc),
		.imm(imm),
		.readA(readA),
		.readB(readB),
		.aluResult(aluResult),
		.aluOut(aluOut)
	);

	assign instrAddr = pc; // pc holds still while a fetch is outstanding
	assign regWriteEn = ctrl.regWrite;
	assign regWriteAddr = writeAddr;
	assign regWriteData = aluOut;

endmodule

`default_nettype wire

// File: testbench/coreTb.sv
`timescale 1ns/100ps
`default_nettype none

module coreTb;

	localparam int MemLatency = 3;
	localparam logic [31:0] ResetPc = 32'h0000_0000;
	localparam logic [31:0] TrapVector = 32'h0000_0100;
	localparam int TableWords = 192; // three words per record
	localparam int MemWords = 256;
	localparam int TimeoutCycles = 50;
	localparam logic [31:0] TagProgram = 32'd1;
	localparam logic [31:0] TagWrite = 32'd2;
	localparam logic [31:0] TagFetch = 32'd3;
	localparam logic [31:0] FillWord = 32'hFC00_0000; // opcode 0x3f decodes as a no-op

	logic clk;
	logic reset;
	logic [31:0] instrData = FillWord;
	logic instrRead;
	logic [31:0] instrAddr;
	logic regWriteEn;
	logic [4:0] regWriteAddr;
	logic [31:0] regWriteData;

	logic [31:0] tests [TableWords];
	logic [31:0] mem [MemWords];
	logic [7:0] fetchIndex;
	int waitLeft;
	int cycle;
	int lastFetch;

	mipsCore #(
		.MemLatency(MemLatency),
		.ResetPc(ResetPc),
		.TrapVector(TrapVector)
	) DUT (
		.clk(clk),
		.reset(reset),
		.instrData(instrData),
		.instrRead(instrRead),
		.instrAddr(instrAddr),
		.regWriteEn(regWriteEn),
		.regWriteAddr(regWriteAddr),
		.regWriteData(regWriteData)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic stopOnFailure(input string reason);
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			stopOnFailure($sformatf("CHECK FAILED %s: got 0x%08h, expected 0x%08h",
				name, actual, expected));
		end
	endtask

	// returns at the falling edge where a fetch or a write-back pulse is seen
	task automatic waitForEvent(output logic [31:0] kind);
		int waited;
		waited = 0;
		kind = '0;
		while (kind == '0) begin
			@(negedge clk);
			cycle++;
			waited++;
			if (instrRead) begin
				kind = TagFetch;
			end else if (regWriteEn) begin
				kind = TagWrite;
			end else if (waited >= TimeoutCycles) begin
				stopOnFailure($sformatf("timeout: no fetch or register write for %0d cycles",
					TimeoutCycles));
			end
		end
	endtask

	// ==================================================
	// instruction memory model
	// ==================================================
	always @(posedge clk) begin
		if (reset) begin
			waitLeft <= 0;
		end else if (instrRead) begin
			if (instrAddr[1:0] != 2'b00 || instrAddr >= 32'(MemWords * 4)) begin
				stopOnFailure($sformatf("fetch from address 0x%08h is outside the memory",
					instrAddr));
			end
			fetchIndex <= instrAddr[9:2];
			waitLeft <= MemLatency - 1;
			if (MemLatency == 1) begin
				instrData <= mem[instrAddr[9:2]];
			end else begin
				instrData <= FillWord; // stale data until the latency is over
			end
		end else if (waitLeft > 0) begin
			waitLeft <= waitLeft - 1;
			if (waitLeft == 1) begin
				instrData <= mem[fetchIndex]; // held until the next request
			end
		end
	end

	// ==================================================
	// stimulus and checking
	// ==================================================
	initial begin
		logic [31:0] tag;
		logic [31:0] kind;
		int eventCount;
		reset = 1'b1;
		eventCount = 0;
		for (int i = 0; i < MemWords; i++) begin
			mem[i] = FillWord | 32'(i * 4);
		end
		for (int i = 0; i < TableWords; i++) begin
			tests[i] = '0;
		end
		$readmemh("testbench/coreTests.hex", tests);
		for (int r = 0; r < TableWords / 3; r++) begin
			if (tests[3 * r] == TagProgram) begin
				mem[tests[3 * r + 1][9:2]] = tests[3 * r + 2];
			end
		end

		repeat (4) @(posedge clk);
		@(negedge clk);
		checkValue("instrRead", 32'(instrRead), 32'd0); // quiet while reset is held
		checkValue("regWriteEn", 32'(regWriteEn), 32'd0);
		@(posedge clk);
		reset <= 1'b0;
		cycle = 0;
		lastFetch = 0;

		for (int r = 0; r < TableWords / 3; r++) begin
			tag = tests[3 * r];
			if (tag == TagFetch || tag == TagWrite) begin
				waitForEvent(kind);
				eventCount++;
				checkValue("event kind", kind, tag); // 3 is a fetch, 2 a write-back
				if (tag == TagFetch) begin
					checkValue("instrAddr", instrAddr, tests[3 * r + 1]);
					checkValue("fetch spacing in cycles", cycle - lastFetch, tests[3 * r + 2]);
					lastFetch = cycle;
				end else begin
					checkValue("regWriteAddr", 32'(regWriteAddr), tests[3 * r + 1]);
					checkValue("regWriteData", regWriteData, tests[3 * r + 2]);
				end
			end else if (tag != TagProgram && tag != '0) begin
				stopOnFailure($sformatf("record %0d of the tests file has an unknown tag", r));
			end
		end

		if (eventCount == 0) begin
			stopOnFailure("the tests file holds no expected fetch or write events");
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: testbench/coreTests.hex
// columns: tag, then two values; tag 1 = program word (address, instruction),
// tag 2 = expected write (register, value), tag 3 = expected fetch (address, cycles since last)
1 00000000 20010005
1 00000004 2002FFFD
1 00000008 24237FFF
1 0000000C 24048000
1 00000010 00222820
1 00000014 00613022
1 00000018 00643824
1 0000001C 20200007
1 00000020 00014020
1 00000024 0000000D
1 00000028 F8221234
1 0000002C 01095022
1 00000100 20290001
1 00000104 00000013
3 00000000 00000001
2 00000001 00000005
3 00000004 00000007
2 00000002 FFFFFFFD
3 00000008 00000007
2 00000003 00008004
3 0000000C 00000007
2 00000004 FFFF8000
3 00000010 00000007
2 00000005 00000002
3 00000014 00000007
2 00000006 00007FFF
3 00000018 00000007
2 00000007 00008000
3 0000001C 00000007
2 00000000 0000000C
3 00000020 00000007
2 00000008 00000005
3 00000024 00000007
3 00000100 00000006
2 00000009 00000006
3 00000104 00000007
3 00000028 00000006
3 0000002C 00000005
2 0000000A FFFFFFFF
3 00000030 00000007

// File: sources.f
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/ctrlIf.sv
hdl/memWaitTimer.sv
hdl/mainControl.sv
hdl/pcUnit.sv
hdl/regFile.sv
hdl/execUnit.sv
hdl/mipsCore.sv
testbench/coreTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= coreTb
RTL_TOP ?= mipsCore
FILE_LIST ?= sources.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert -Wno-fatal
LINT_FLAGS ?= -Wall
PASS_MSG ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
